/* flist.f */
accel_net_pkg.sv
rx_meta_if.sv
udp_rx_parser.sv
sample_loader.sv
udp_tx_builder.sv
accel_udp_top.sv
tb_accel_udp.sv

/* Makefile */
# verilator build and run for the accelerator udp front end

VERILATOR ?= verilator
TOP       ?= tb_accel_udp
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb_accel_udp.sv */
//----------------------------------------------------------------------
// testbench for the accelerator udp front end
// drives rx frames and nn results, assertions check writes and replies
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_accel_udp
  import accel_net_pkg::*;
();

  localparam mac_addr_t MAC  = 48'h000a35000001;
  localparam ip_addr_t  IP   = 32'h01010102;
  localparam udp_port_t PORT = 16'd666;
  localparam int        NS   = 16;
  localparam int        TMO  = 400;

  logic         gtx_clk_bufg = 1'b0;
  logic         rst_n;
  byte_t        rx_tdata;
  logic         rx_tvalid, rx_tlast, rx_tready;
  logic         w_en, w_done, result_valid, tx_ready;
  sample_addr_t w_addr;
  sample_t      w_data;
  result_t      result_msg;
  byte_t        tx_tdata;
  logic         tx_tvalid, tx_tlast, tx_tready;

  //--------------------------------------------------------------------
  // scoreboard state
  //--------------------------------------------------------------------
  int        errors = 0;
  string     test_name = "reset";
  byte_t     pay_bytes [0:31];
  // w_done allowed for the frame on the wire
  logic      frame_good = 1'b0;
  logic      reply_pending = 1'b0;
  int        wr_cnt, done_cnt, tx_cnt, tx_frames;
  logic [2:0] last_d;
  // reply target of the last loaded frame
  mac_addr_t good_mac;
  ip_addr_t  good_ip;
  udp_port_t good_port;
  result_t   exp_res;
  byte_t     exp_tx;

  accel_udp_top #(
    .MY_MAC(MAC), .MY_IP(IP), .MY_PORT(PORT), .SAMPLE_BYTES(NS)
  ) u_dut (.*);

  always #2 gtx_clk_bufg = ~gtx_clk_bufg;

  task automatic mismatch(string what, longint expv, longint actv);
    errors++;
    $display("FAILED %s: %s expected %0h actual %0h", test_name, what, expv, actv);
  endtask

  task automatic problem(string msg);
    errors++;
    $display("error in %s: %s", test_name, msg);
  endtask

  function automatic sample_t scaled(byte_t b);
    return sample_t'(32'(b) << PIXEL_SHIFT);
  endfunction

  // reply byte at position i from the frame layout
  function automatic byte_t reply_byte(int i, mac_addr_t dm, ip_addr_t di,
                                       udp_port_t dp, result_t r);
    byte_t b;
    b = 8'h00;
    if (i < 6) b = dm[8*(5-i) +: 8];
    else if (i < 12) b = MAC[8*(11-i) +: 8];
    else if (i == 12) b = 8'h08;
    else if (i == 14) b = 8'h45;
    else if (i == 17) b = 8'd30;
    else if (i == 22) b = 8'd64;
    else if (i == 23) b = 8'd17;
    else if (i >= 26 && i < 30) b = IP[8*(29-i) +: 8];
    else if (i >= 30 && i < 34) b = di[8*(33-i) +: 8];
    else if (i == 34 || i == 35) b = PORT[8*(35-i) +: 8];
    else if (i == 36 || i == 37) b = dp[8*(37-i) +: 8];
    else if (i == 39) b = 8'd10;
    else if (i == 42) b = {6'd0, r[9:8]};
    else if (i == 43) b = r[7:0];
    return b;
  endfunction

  assign exp_tx = reply_byte(tx_cnt, good_mac, good_ip, good_port, exp_res);

  // write, load and reply beat counters
  always @(posedge gtx_clk_bufg) begin
    if (!rst_n) begin
      last_d    <= '0;
      wr_cnt    <= 0;
      done_cnt  <= 0;
      tx_cnt    <= 0;
      tx_frames <= 0;
    end else begin
      last_d <= {last_d[1:0], rx_tvalid && rx_tready && rx_tlast};
      // restart the write index once the frame has drained
      if (last_d[2])
        wr_cnt <= 0;
      else if (w_en)
        wr_cnt <= wr_cnt + 1;
      if (w_done)
        done_cnt <= done_cnt + 1;
      if (tx_tvalid && tx_tready) begin
        tx_cnt <= tx_tlast ? 0 : tx_cnt + 1;
        if (tx_tlast)
          tx_frames <= tx_frames + 1;
      end
    end
  end

  //--------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------
  a_wr_addr: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    w_en |-> w_addr == sample_addr_t'(wr_cnt))
    else mismatch("w_addr", $sampled(wr_cnt), $sampled(w_addr));
  a_wr_data: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    w_en |-> w_data == scaled(pay_bytes[wr_cnt]))
    else mismatch("w_data", scaled(pay_bytes[$sampled(wr_cnt)]), $sampled(w_data));
  // done lands with the last of exactly NS writes
  a_done_count: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    w_done |-> w_en && wr_cnt == NS - 1)
    else mismatch("writes at w_done", NS, $sampled(wr_cnt) + 1);
  // w_done two cycles after the tlast byte
  a_done_latency: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    w_done |-> last_d[1])
    else problem("w_done not two cycles after the tlast byte");
  a_done_good: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    w_done |-> frame_good)
    else problem("w_done for a frame that should be rejected");
  a_rx_ready: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    rx_tvalid |-> rx_tready)
    else problem("rx_tready low while a frame is sent");
  a_tx_data: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    tx_tvalid && tx_tready |-> tx_tdata == exp_tx)
    else mismatch($sformatf("reply byte %0d", $sampled(tx_cnt)), $sampled(exp_tx),
                  $sampled(tx_tdata));
  a_tx_last: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    tx_tvalid && tx_tready |-> tx_tlast == (tx_cnt == MIN_FRAME_BYTES - 1))
    else mismatch("tx_tlast", $sampled(tx_cnt) == MIN_FRAME_BYTES - 1, $sampled(tx_tlast));
  a_tx_hold: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata))
    else problem("reply byte dropped or changed under back-pressure");
  a_tx_start: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    tx_ready && result_valid |=> tx_tvalid)
    else problem("tx_tvalid did not rise one cycle after the result");
  a_tx_busy: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    tx_tvalid |-> !tx_ready && reply_pending)
    else problem("tx_ready high during a reply or an unexpected reply frame");

  //--------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------
  task automatic send_frame(mac_addr_t dm, ip_addr_t di, udp_port_t dp,
                            logic [15:0] et, byte_t pr, int npay, logic good);
    byte_t     hdr [0:41];
    mac_addr_t sm;
    ip_addr_t  si;
    udp_port_t sp;
    int        t;
    int        d0;
    sm = mac_addr_t'({$urandom, $urandom});
    si = $urandom;
    sp = udp_port_t'($urandom);
    for (int i = 0; i < 42; i++)
      hdr[i] = 8'h00;
    for (int i = 0; i < 6; i++) begin
      hdr[i]   = dm[8*(5-i) +: 8];
      hdr[6+i] = sm[8*(5-i) +: 8];
    end
    hdr[12] = et[15:8];
    hdr[13] = et[7:0];
    hdr[14] = 8'h45;
    hdr[22] = 8'd64;
    hdr[23] = pr;
    for (int i = 0; i < 4; i++) begin
      hdr[26+i] = si[8*(3-i) +: 8];
      hdr[30+i] = di[8*(3-i) +: 8];
    end
    hdr[34] = sp[15:8];
    hdr[35] = sp[7:0];
    hdr[36] = dp[15:8];
    hdr[37] = dp[7:0];
    for (int i = 0; i < npay; i++)
      pay_bytes[i] = byte_t'($urandom);
    frame_good = good;
    t = 0;
    while (!rx_tready && t < TMO) begin
      @(negedge gtx_clk_bufg);
      t++;
    end
    if (!rx_tready)
      problem("timeout waiting for rx_tready");
    d0 = done_cnt;
    // back to back bytes as the parser never stalls
    for (int i = 0; i < 42 + npay; i++) begin
      @(negedge gtx_clk_bufg);
      rx_tvalid = 1'b1;
      rx_tdata  = (i < 42) ? hdr[i] : pay_bytes[i-42];
      rx_tlast  = (i == 41 + npay);
    end
    @(negedge gtx_clk_bufg);
    rx_tvalid = 1'b0;
    rx_tlast  = 1'b0;
    if (good) begin
      t = 0;
      while (done_cnt == d0 && t < TMO) begin
        @(negedge gtx_clk_bufg);
        t++;
      end
      if (done_cnt == d0) begin
        problem("timeout waiting for w_done");
      end else begin
        good_mac  = sm;
        good_ip   = si;
        good_port = sp;
      end
    end
    // gap where a stray w_done would show
    repeat (4) @(negedge gtx_clk_bufg);
    assert (done_cnt == d0 + int'(good))
      else mismatch("w_done count", d0 + int'(good), done_cnt);
  endtask

  task automatic send_result(logic rand_rdy);
    int      t;
    int      f0;
    result_t r;
    r = result_t'($urandom);
    t = 0;
    while (!tx_ready && t < TMO) begin
      @(negedge gtx_clk_bufg);
      t++;
    end
    if (!tx_ready)
      problem("timeout waiting for tx_ready");
    f0            = tx_frames;
    exp_res       = r;
    reply_pending = 1'b1;
    result_msg    = r;
    result_valid  = 1'b1;
    @(negedge gtx_clk_bufg);
    t = 0;
    while (tx_frames == f0 && t < TMO) begin
      tx_tready = rand_rdy ? 1'($urandom) : 1'b1;
      // a second result mid frame is ignored
      result_valid = (t == 8);
      result_msg   = ~r;
      @(negedge gtx_clk_bufg);
      t++;
    end
    tx_tready     = 1'b1;
    result_valid  = 1'b0;
    reply_pending = 1'b0;
    if (tx_frames == f0)
      problem("timeout waiting for the reply frame");
    // tx_tvalid in this gap would be a second frame
    repeat (4) @(negedge gtx_clk_bufg);
  endtask

  initial begin
    void'($urandom(32'hb825_7411));
    rst_n        = 1'b0;
    rx_tdata     = '0;
    rx_tvalid    = 1'b0;
    rx_tlast     = 1'b0;
    result_valid = 1'b0;
    result_msg   = '0;
    tx_tready    = 1'b1;
    repeat (5) @(negedge gtx_clk_bufg);
    assert (!rx_tready && !w_en && !w_done && !tx_tvalid && !tx_tlast && tx_ready)
      else problem("outputs not at their reset values");
    rst_n = 1'b1;

    test_name = "good_frame";
    send_frame(MAC, IP, PORT, 16'h0800, 8'd17, NS, 1'b1);
    // each frame breaks one checked header field
    test_name = "rejected_frames";
    send_frame(MAC ^ 48'h1, IP, PORT, 16'h0800, 8'd17, NS, 1'b0);
    send_frame(MAC, IP ^ 32'h100, PORT, 16'h0800, 8'd17, NS, 1'b0);
    send_frame(MAC, IP, PORT + 16'd1, 16'h0800, 8'd17, NS, 1'b0);
    send_frame(MAC, IP, PORT, 16'h86dd, 8'd17, NS, 1'b0);
    send_frame(MAC, IP, PORT, 16'h0800, 8'd6, NS, 1'b0);
    test_name = "reply";
    send_result(1'b0);
    test_name = "bad_length";
    send_frame(MAC, IP, PORT, 16'h0800, 8'd17, NS - 1, 1'b0);
    send_frame(MAC, IP, PORT, 16'h0800, 8'd17, NS + 1, 1'b0);
    send_frame(MAC, IP, PORT, 16'h0800, 8'd17, NS, 1'b1);
    test_name = "reply_backpressure";
    send_result(1'b1);

    $display("summary: %0d errors, %0d loads, %0d reply frames", errors, done_cnt, tx_frames);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* accel_udp_top.sv */
//--------------------------------------------------------------------
// accelerator udp front end, rx parse and load, tx reply
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module accel_udp_top
  import accel_net_pkg::*;
#(
  parameter mac_addr_t MY_MAC       = 48'h000a35000001,
  parameter ip_addr_t  MY_IP        = 32'h01010102,
  parameter udp_port_t MY_PORT      = 16'd666,
  parameter int        SAMPLE_BYTES = 784
) (
  input  wire logic  gtx_clk_bufg,
  input  wire logic  rst_n,
  // mac rx fifo stream
  input  wire byte_t rx_tdata,
  input  wire logic  rx_tvalid,
  input  wire logic  rx_tlast,
  output logic       rx_tready,
  // nn input buffer write port
  output logic         w_en,
  output sample_addr_t w_addr,
  output sample_t      w_data,
  output logic         w_done,
  // nn result
  input  wire logic    result_valid,
  input  wire result_t result_msg,
  output logic         tx_ready,
  // mac tx fifo stream
  output byte_t      tx_tdata,
  output logic       tx_tvalid,
  output logic       tx_tlast,
  input  wire logic  tx_tready
);

  mac_addr_t sender_mac;
  ip_addr_t  sender_ip;
  udp_port_t sender_port;

  rx_meta_if meta ();

  udp_rx_parser #(
    .MY_MAC(MY_MAC), .MY_IP(MY_IP), .MY_PORT(MY_PORT), .SAMPLE_BYTES(SAMPLE_BYTES)
  ) u_parser (
    .gtx_clk_bufg(gtx_clk_bufg), .rst_n(rst_n),
    .rx_tdata(rx_tdata), .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast),
    .rx_tready(rx_tready), .meta(meta.parser)
  );

  sample_loader u_loader (
    .gtx_clk_bufg(gtx_clk_bufg), .rst_n(rst_n), .meta(meta.loader),
    .w_en(w_en), .w_addr(w_addr), .w_data(w_data), .w_done(w_done),
    .sender_mac(sender_mac), .sender_ip(sender_ip), .sender_port(sender_port)
  );

  udp_tx_builder #(
    .MY_MAC(MY_MAC), .MY_IP(MY_IP), .MY_PORT(MY_PORT)
  ) u_builder (
    .gtx_clk_bufg(gtx_clk_bufg), .rst_n(rst_n),
    .result_valid(result_valid), .result_msg(result_msg),
    .sender_mac(sender_mac), .sender_ip(sender_ip), .sender_port(sender_port),
    .tx_ready(tx_ready), .tx_tdata(tx_tdata), .tx_tvalid(tx_tvalid),
    .tx_tlast(tx_tlast), .tx_tready(tx_tready)
  );

endmodule

`default_nettype wire

/* udp_tx_builder.sv */
//--------------------------------------------------------------------
// udp reply builder
// sends the 60 byte result frame to the held sender
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module udp_tx_builder
  import accel_net_pkg::*;
#(
  parameter mac_addr_t MY_MAC  = 48'h000a35000001,
  parameter ip_addr_t  MY_IP   = 32'h01010102,
  parameter udp_port_t MY_PORT = 16'd666
) (
  input  wire logic      gtx_clk_bufg,
  input  wire logic      rst_n,
  input  wire logic      result_valid,
  input  wire result_t   result_msg,
  input  wire mac_addr_t sender_mac,
  input  wire ip_addr_t  sender_ip,
  input  wire udp_port_t sender_port,
  output logic           tx_ready,
  output byte_t          tx_tdata,
  output logic           tx_tvalid,
  output logic           tx_tlast,
  input  wire logic      tx_tready
);

  localparam frame_idx_t FRAME_LAST = frame_idx_t'(MIN_FRAME_BYTES - 1);
  localparam int         PAD_BYTES  = MIN_FRAME_BYTES - HDR_BYTES - 2;

  tx_state_t  state;
  frame_idx_t idx;
  logic       start;

  // captured at start, held for the whole frame
  result_t    res_q;
  mac_addr_t  dst_mac_q;
  ip_addr_t   dst_ip_q;
  udp_port_t  dst_port_q;

  logic [8*MIN_FRAME_BYTES-1:0] reply;

  assign start = (state == IDLE) && result_valid;

  //------------------------------------------------------------------
  // reply image, byte 0 in the top bits
  //------------------------------------------------------------------
  assign reply = {
    // ethernet
    dst_mac_q, MY_MAC, ETHERTYPE_IPV4,
    // ipv4, checksum left at zero
    8'h45, 8'h00, IP_TOTAL_LEN, 32'h0,
    IP_TTL, IP_PROTO_UDP, 16'h0, MY_IP, dst_ip_q,
    // udp
    MY_PORT, dst_port_q, UDP_LEN, 16'h0,
    // result, high byte first
    {(16-RESULT_W){1'b0}}, res_q,
    {(8*PAD_BYTES){1'b0}}
  };

  always_ff @(posedge gtx_clk_bufg) begin
    if (start) begin
      res_q      <= result_msg;
      dst_mac_q  <= sender_mac;
      dst_ip_q   <= sender_ip;
      dst_port_q <= sender_port;
    end
  end

  // walk the frame, advance on accepted beats only
  always_ff @(posedge gtx_clk_bufg) begin
    if (!rst_n) begin
      state <= IDLE;
      idx   <= '0;
    end else begin
      case (state)
        IDLE: if (result_valid) begin
          state <= SEND;
          idx   <= '0;
        end
        default: if (tx_tready) begin
          if (idx == FRAME_LAST) begin
            state <= IDLE;
          end else begin
            idx <= idx + 1'b1;
          end
        end
      endcase
    end
  end

  assign tx_ready  = (state == IDLE);
  assign tx_tvalid = (state == SEND);
  assign tx_tlast  = (state == SEND) && (idx == FRAME_LAST);
  assign tx_tdata  = reply[8*(MIN_FRAME_BYTES-1-idx) +: 8];

  // a stalled beat keeps its byte
  a_tdata_hold: assert property (@(posedge gtx_clk_bufg)
    disable iff (!rst_n)
    tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata));

endmodule

`default_nettype wire

/* sample_loader.sv */
//--------------------------------------------------------------------
// sample loader
// scales payload bytes into nn input samples, holds the reply target
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sample_loader
  import accel_net_pkg::*;
(
  input  wire logic    gtx_clk_bufg,
  input  wire logic    rst_n,
  rx_meta_if.loader    meta,
  output logic         w_en,
  output sample_addr_t w_addr,
  output sample_t      w_data,
  output logic         w_done,
  output mac_addr_t    sender_mac,
  output ip_addr_t     sender_ip,
  output udp_port_t    sender_port
);

  // write and done strobes, one cycle behind the parser
  always_ff @(posedge gtx_clk_bufg) begin
    if (!rst_n) begin
      w_en   <= 1'b0;
      w_done <= 1'b0;
    end else begin
      w_en   <= meta.payload_en;
      w_done <= meta.frame_ready;
    end
  end

  // byte zero extended then shifted into fixed point
  always_ff @(posedge gtx_clk_bufg) begin
    if (meta.payload_en) begin
      w_addr <= meta.payload_addr;
      w_data <= {{(SAMPLE_W-8-PIXEL_SHIFT){1'b0}}, meta.payload_data,
                 {PIXEL_SHIFT{1'b0}}};
    end
  end

  // reply target moves only on an accepted frame
  always_ff @(posedge gtx_clk_bufg) begin
    if (!rst_n) begin
      sender_mac  <= '0;
      sender_ip   <= '0;
      sender_port <= '0;
    end else if (meta.frame_ready) begin
      sender_mac  <= meta.src_mac;
      sender_ip   <= meta.src_ip;
      sender_port <= meta.src_port;
    end
  end

  // last sample write lands together with done
  a_done_with_last_write: assert property (@(posedge gtx_clk_bufg)
    disable iff (!rst_n) w_done |-> w_en);

endmodule

`default_nettype wire

/* udp_rx_parser.sv */
//--------------------------------------------------------------------
// udp receive parser
// filters eth/ipv4/udp frames on our address and length, emits payload
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module udp_rx_parser
  import accel_net_pkg::*;
#(
  parameter mac_addr_t MY_MAC       = 48'h000a35000001,
  parameter ip_addr_t  MY_IP        = 32'h01010102,
  parameter udp_port_t MY_PORT      = 16'd666,
  parameter int        SAMPLE_BYTES = 784
) (
  input  wire logic   gtx_clk_bufg,
  input  wire logic   rst_n,
  input  wire byte_t  rx_tdata,
  input  wire logic   rx_tvalid,
  input  wire logic   rx_tlast,
  output logic        rx_tready,
  rx_meta_if.parser   meta
);

  localparam frame_idx_t   HDR_LAST = frame_idx_t'(HDR_BYTES - 1);
  localparam sample_addr_t PAY_LAST = sample_addr_t'(SAMPLE_BYTES - 1);

  rx_state_t    state;
  frame_idx_t   hdr_cnt;
  sample_addr_t pay_cnt;
  logic         hdr_ok;
  logic         beat;
  logic         chk_en;
  byte_t        exp_byte;
  logic         byte_ok;

  assign beat    = rx_tvalid && rx_tready;
  assign byte_ok = !chk_en || (rx_tdata == exp_byte);

  // expected value of each checked header byte
  always_comb begin
    chk_en   = 1'b0;
    exp_byte = '0;
    if (hdr_cnt < SRC_MAC_OFS) begin
      chk_en   = 1'b1;
      exp_byte = MY_MAC[8*(SRC_MAC_OFS-1-hdr_cnt) +: 8];
    end else if (hdr_cnt == ETH_TYPE_OFS || hdr_cnt == ETH_TYPE_OFS + 1) begin
      chk_en   = 1'b1;
      exp_byte = ETHERTYPE_IPV4[8*(ETH_TYPE_OFS+1-hdr_cnt) +: 8];
    end else if (hdr_cnt == IP_PROTO_OFS) begin
      chk_en   = 1'b1;
      exp_byte = IP_PROTO_UDP;
    end else if (hdr_cnt >= DST_IP_OFS && hdr_cnt < SRC_PORT_OFS) begin
      chk_en   = 1'b1;
      exp_byte = MY_IP[8*(SRC_PORT_OFS-1-hdr_cnt) +: 8];
    end else if (hdr_cnt >= DST_PORT_OFS && hdr_cnt < DST_PORT_OFS + 2) begin
      chk_en   = 1'b1;
      exp_byte = MY_PORT[8*(DST_PORT_OFS+1-hdr_cnt) +: 8];
    end
  end

  //------------------------------------------------------------------
  // frame fsm
  //------------------------------------------------------------------
  always_ff @(posedge gtx_clk_bufg) begin
    if (!rst_n) begin
      rx_tready        <= 1'b0;
      state            <= HEADER;
      hdr_cnt          <= '0;
      pay_cnt          <= '0;
      hdr_ok           <= 1'b0;
      meta.payload_en  <= 1'b0;
      meta.frame_ready <= 1'b0;
    end else begin
      // never stall the mac fifo
      rx_tready        <= 1'b1;
      meta.payload_en  <= 1'b0;
      meta.frame_ready <= 1'b0;
      case (state)
        HEADER: if (beat) begin
          // first byte restarts the running match
          hdr_ok <= ((hdr_cnt == '0) ? 1'b1 : hdr_ok) && byte_ok;
          if (rx_tlast) begin
            hdr_cnt <= '0;
          end else if (hdr_cnt == HDR_LAST) begin
            hdr_cnt <= '0;
            pay_cnt <= '0;
            state   <= (hdr_ok && byte_ok) ? PAYLOAD : DISCARD;
          end else begin
            hdr_cnt <= hdr_cnt + 1'b1;
          end
        end
        PAYLOAD: if (beat) begin
          meta.payload_en <= 1'b1;
          if (rx_tlast) begin
            // only an exact length frame is handed on
            meta.frame_ready <= (pay_cnt == PAY_LAST);
            state            <= HEADER;
          end else if (pay_cnt == PAY_LAST) begin
            // too long, drop the rest
            state <= DISCARD;
          end else begin
            pay_cnt <= pay_cnt + 1'b1;
          end
        end
        default: if (beat && rx_tlast) begin
          state <= HEADER;
        end
      endcase
    end
  end

  // payload byte and sender fields
  always_ff @(posedge gtx_clk_bufg) begin
    if (state == PAYLOAD && beat) begin
      meta.payload_data <= rx_tdata;
      meta.payload_addr <= pay_cnt;
    end
    if (state == HEADER && beat) begin
      if (hdr_cnt >= SRC_MAC_OFS && hdr_cnt < ETH_TYPE_OFS)
        meta.src_mac <= {meta.src_mac[MAC_W-9:0], rx_tdata};
      if (hdr_cnt >= SRC_IP_OFS && hdr_cnt < DST_IP_OFS)
        meta.src_ip <= {meta.src_ip[IP_W-9:0], rx_tdata};
      if (hdr_cnt >= SRC_PORT_OFS && hdr_cnt < DST_PORT_OFS)
        meta.src_port <= {meta.src_port[PORT_W-9:0], rx_tdata};
    end
  end

  // payload index must fit the sample buffer address
  a_sample_bytes_fit: assert property (@(posedge gtx_clk_bufg)
    SAMPLE_BYTES >= 1 && SAMPLE_BYTES <= 2**$bits(sample_addr_t));

endmodule

`default_nettype wire

/* rx_meta_if.sv */
//--------------------------------------------------------------------
// rx metadata link, parser to sample loader
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface rx_meta_if
  import accel_net_pkg::*;
();

  // one pulse per payload byte
  logic         payload_en;
  byte_t        payload_data;
  sample_addr_t payload_addr;
  // accepted frame, sender fields valid here
  logic         frame_ready;
  mac_addr_t    src_mac;
  ip_addr_t     src_ip;
  udp_port_t    src_port;

  modport parser (
    output payload_en, payload_data, payload_addr,
    output frame_ready, src_mac, src_ip, src_port
  );

  modport loader (
    input payload_en, payload_data, payload_addr,
    input frame_ready, src_mac, src_ip, src_port
  );

endinterface

`default_nettype wire

/* accel_net_pkg.sv */
//--------------------------------------------------------------------
// accelerator network package
// frame field widths, header constants, offsets and shared types
//--------------------------------------------------------------------
`default_nettype none

package accel_net_pkg;

  // field widths
  localparam int MAC_W    = 48;
  localparam int IP_W     = 32;
  localparam int PORT_W   = 16;
  localparam int SAMPLE_W = 18;
  localparam int RESULT_W = 10;

  typedef logic [MAC_W-1:0]           mac_addr_t;
  typedef logic [IP_W-1:0]            ip_addr_t;
  typedef logic [PORT_W-1:0]          udp_port_t;
  typedef logic [7:0]                 byte_t;
  typedef logic [9:0]                 sample_addr_t;
  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic [RESULT_W-1:0]        result_t;
  // byte index inside header or reply frame, max 63
  typedef logic [5:0]                 frame_idx_t;

  // fixed point scaling of each pixel byte
  localparam int PIXEL_SHIFT = 2;

  //------------------------------------------------------------------
  // header constants
  //------------------------------------------------------------------
  localparam int        HDR_BYTES       = 42;
  localparam int        MIN_FRAME_BYTES = 60;
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
  localparam logic [7:0]  IP_TTL         = 8'd64;
  // ip header + udp header + 2 result bytes
  localparam logic [15:0] IP_TOTAL_LEN   = 16'd30;
  localparam logic [15:0] UDP_LEN        = 16'd10;

  // byte offsets from start of frame
  localparam int DST_MAC_OFS  = 0;
  localparam int SRC_MAC_OFS  = 6;
  localparam int ETH_TYPE_OFS = 12;
  localparam int IP_PROTO_OFS = 23;
  localparam int SRC_IP_OFS   = 26;
  localparam int DST_IP_OFS   = 30;
  localparam int SRC_PORT_OFS = 34;
  localparam int DST_PORT_OFS = 36;
  localparam int PAYLOAD_OFS  = 42;

  typedef enum logic [1:0] {HEADER, PAYLOAD, DISCARD} rx_state_t;
  typedef enum logic {IDLE, SEND} tx_state_t;

endpackage

`default_nettype wire
